//--- hdl/sha256_pkg.sv
/*
  Shared definitions for the two-engine SHA-256 subsystem.
  Holds sizes, round constants, initial hash words, the 512-bit block union
  and the word functions of FIPS 180-4. Modules pull it in with a wildcard import
*/

package sha256_pkg;

  localparam int BLK_BYTS = 64;            // Bytes per message block
  localparam int BLK_BITS = BLK_BYTS * 8;  // Bits per message block
  localparam int DIG_BITS = 256;           // Bits per digest
  localparam int ROUNDS   = 64;            // Compression rounds per block
  localparam int MOD_W    = 6;             // Last-block byte count, 0 means all 64 valid
  localparam int N_ENG    = 2;             // Number of hash engines
  localparam int ENG_W    = $clog2(N_ENG); // Width of an engine index
  localparam int TAG_W    = 4;             // Width of the sequence tag

  // Engine FSM encodings
  localparam logic [1:0] SHA_IDLE   = 2'd0; // Waiting for a start of message
  localparam logic [1:0] SHA_ROUNDS = 2'd1; // Running the 64 rounds
  localparam logic [1:0] SHA_UPDATE = 2'd2; // Folding the working vars into H
  localparam logic [1:0] SHA_FINAL  = 2'd3; // Digest presented, waiting for ready

  // Round constants, first 32 bits of the cube roots of the first 64 primes
  localparam logic [31:0] K [ROUNDS] = '{
    32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
    32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
    32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
    32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
    32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
    32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
    32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
    32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
    32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
    32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
    32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
    32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
    32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
    32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
    32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
    32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
  };

  // Initial hash value H(0), big endian words
  localparam logic [31:0] IV [8] = '{
    32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
    32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19
  };

  // One 512-bit block, byte 0 of the message sits in bits 7:0
  // The word view feeds the schedule and the byte view places the 0x80 terminator
  typedef union packed {
    logic [15:0][31:0] w; // Word i is bits 32i+31 to 32i
    logic [63:0][7:0]  b; // Byte k is bits 8k+7 to 8k
  } sha_block_u;

  // Rotate right, only used by the sigma functions below
  function automatic logic [31:0] rotr(input logic [31:0] x, input int unsigned n);
    return (x >> n) | (x << (32 - n));
  endfunction

  // Swap a little endian stream word into the big endian order SHA works in
  function automatic logic [31:0] bs32(input logic [31:0] x);
    return {x[7:0], x[15:8], x[23:16], x[31:24]};
  endfunction

  function automatic logic [31:0] big_sig0(input logic [31:0] x);
    return rotr(x, 2) ^ rotr(x, 13) ^ rotr(x, 22);
  endfunction

  function automatic logic [31:0] big_sig1(input logic [31:0] x);
    return rotr(x, 6) ^ rotr(x, 11) ^ rotr(x, 25);
  endfunction

  // Message schedule sigmas, the last term is a plain shift
  function automatic logic [31:0] little_sig0(input logic [31:0] x);
    return rotr(x, 7) ^ rotr(x, 18) ^ (x >> 3);
  endfunction

  function automatic logic [31:0] little_sig1(input logic [31:0] x);
    return rotr(x, 17) ^ rotr(x, 19) ^ (x >> 10);
  endfunction

  // Choose, e picks bits from f or g
  function automatic logic [31:0] ch(input logic [31:0] e, input logic [31:0] f,
                                     input logic [31:0] g);
    return (e & f) ^ (~e & g);
  endfunction

  // Majority of the three inputs per bit
  function automatic logic [31:0] maj(input logic [31:0] a, input logic [31:0] b,
                                      input logic [31:0] c);
    return (a & b) ^ (a & c) ^ (b & c);
  endfunction

endpackage

//--- hdl/sha256_dispatch.sv
/*
  Message dispatcher. Steers each whole message to the lowest numbered idle
  engine and holds that engine until the end of message transfer.
  Also owns the sequence tag counter that every message is stamped with
*/

`timescale 1ns/1ns

module sha256_dispatch
  import sha256_pkg::*;
(
  input  logic             i_clk,
  input  logic             i_rst,
  input  logic             i_blk_val,
  output logic             o_blk_rdy,
  input  logic             i_blk_sop,
  input  logic             i_blk_eop,
  input  logic [N_ENG-1:0] i_eng_rdy, // Ready with sop pending means idle
  output logic [N_ENG-1:0] o_eng_val,
  output logic [TAG_W-1:0] o_tag      // Tag of the message now entering
);

  logic             busy;   // A message is open on the owner engine
  logic [ENG_W-1:0] owner;
  logic [ENG_W-1:0] sel;    // Lowest idle engine
  logic [ENG_W-1:0] cur;    // Engine the input is steered to this cycle
  logic             route;  // Input has somewhere to go
  logic [TAG_W-1:0] tag;

  assign o_tag = tag;

  always_comb begin
    sel = '0;
    for (int e = N_ENG - 1; e >= 0; e--) begin
      if (i_eng_rdy[e])
        sel = ENG_W'(e); // Last hit wins so the lowest index is picked
    end
    cur   = busy ? owner : sel;
    route = busy || (i_blk_sop && (|i_eng_rdy)); // No idle engine stalls a new message
    o_eng_val = '0;
    if (route && i_blk_val)
      o_eng_val[cur] = 1'b1;
    o_blk_rdy = route && i_eng_rdy[cur];
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      busy  <= 1'b0;
      owner <= '0;
      tag   <= '0;
    end else if (i_blk_val && o_blk_rdy) begin
      if (i_blk_eop) begin
        busy <= 1'b0;          // Engine is released here and single-block messages never set busy
        tag  <= tag + 1'b1;    // Wraps after 2^TAG_W messages
      end else begin
        busy <= 1'b1;
        if (!busy)
          owner <= sel;        // Captured on the start of message transfer
      end
    end
  end

  // All blocks of one message go to the engine that took its first block
  a_one_eng: assert property (@(posedge i_clk) disable iff (i_rst)
    i_blk_val && o_blk_rdy && !i_blk_eop |=> (o_eng_val & ~$past(o_eng_val)) == '0);

endmodule

//--- hdl/sha256_core.sv
/*
  One SHA-256 hash engine. Takes whole messages as 512-bit blocks, pads the
  last one with 0x80 and the 64-bit bit length (or adds a padding-only block),
  runs 64 rounds per block and chains the result. The digest is held with the
  sequence tag latched at start of message until the output accepts it
*/

`timescale 1ns/1ns

module sha256_core
  import sha256_pkg::*;
(
  input  logic                i_clk,
  input  logic                i_rst,
  input  logic                i_blk_val,  // Block valid from the dispatcher
  output logic                o_blk_rdy,  // High in idle or when the next block may come
  input  logic                i_blk_sop,
  input  logic                i_blk_eop,
  input  logic [MOD_W-1:0]    i_blk_mod,  // Valid bytes in the last block, 0 means all
  input  sha_block_u          i_blk_dat,
  input  logic [TAG_W-1:0]    i_blk_tag,  // Sequence tag, sampled at start of message
  output logic                o_dig_val,
  input  logic                i_dig_rdy,
  output logic [DIG_BITS-1:0] o_dig_dat,  // First digest byte in bits 7:0
  output logic [TAG_W-1:0]    o_dig_tag
);

  logic [1:0]             state;
  logic [5:0]             rnd;         // Round counter, also indexes K
  logic [15:0][31:0]      w;           // Schedule window, w[0] is used this round
  logic [31:0]            w_nxt;       // Next schedule word shifted in at the top
  logic [7:0][31:0]       v;           // Working vars a..h at index 0..7
  logic [7:0][31:0]       h;           // Chaining value
  logic [31:0]            t1, t2;
  logic [63:0]            bit_len;     // Message bits taken so far
  logic [63:0]            len_nxt;     // Bit length including the block now offered
  logic [9:0]             len_add;
  logic                   pad_only;    // A padding-only block still has to run
  logic                   final_blk;   // The block in flight is the last one
  logic                   need_pad;    // Tail leaves no room for the length
  logic                   blk_acc;
  sha_block_u             blk_pad;     // Incoming block with tail bytes cleared
  logic [15:0][31:0]      w_load;      // Big endian words to load into the window
  logic [15:0][31:0]      w_pad;       // Contents of the padding-only block
  logic                   dig_val;
  logic [TAG_W-1:0]       tag;

  assign blk_acc   = o_blk_rdy && i_blk_val;
  assign o_dig_val = dig_val;
  assign o_dig_tag = tag;

  // Tail does not fit when the block is full or fewer than 9 bytes remain
  assign need_pad = (i_blk_mod == '0) || (i_blk_mod > MOD_W'(BLK_BYTS - 9));

  always_comb begin
    // Bits added by this block, only a short last block adds less than 512
    len_add = (i_blk_eop && i_blk_mod != '0) ? 10'({i_blk_mod, 3'b000}) : 10'(BLK_BITS);
    len_nxt = bit_len + 64'(len_add);

    blk_pad = i_blk_dat;
    if (i_blk_eop && i_blk_mod != '0) begin
      for (int k = 0; k < BLK_BYTS; k++) begin
        if (k >= int'(i_blk_mod))
          blk_pad.b[k] = 8'h00; // Stale bytes beyond the message end
      end
      blk_pad.b[i_blk_mod] = 8'h80; // Terminator right after the last byte
    end

    for (int i = 0; i < 16; i++)
      w_load[i] = bs32(blk_pad.w[i]);
    // The length goes inline when the tail leaves room for it
    if (i_blk_eop && !need_pad) begin
      w_load[14] = len_nxt[63:32];
      w_load[15] = len_nxt[31:0];
    end
  end

  // Padding-only block, a full last block still owes the 0x80 byte in word 0
  always_comb begin
    w_pad     = '0;
    w_pad[0]  = (bit_len[8:0] == '0) ? 32'h8000_0000 : 32'h0;
    w_pad[14] = bit_len[63:32];
    w_pad[15] = bit_len[31:0];
  end

  always_comb begin
    w_nxt = little_sig1(w[14]) + w[9] + little_sig0(w[1]) + w[0];
    t1    = v[7] + big_sig1(v[4]) + ch(v[4], v[5], v[6]) + K[rnd] + w[0];
    t2    = big_sig0(v[0]) + maj(v[0], v[1], v[2]);
  end

  // H words go back to stream byte order so the digest matches the input
  always_comb begin
    for (int i = 0; i < 8; i++)
      o_dig_dat[i*32 +: 32] = bs32(h[i]);
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state     <= SHA_IDLE;
      rnd       <= '0;
      o_blk_rdy <= 1'b0;
      dig_val   <= 1'b0;
      bit_len   <= '0;
      pad_only  <= 1'b0;
      final_blk <= 1'b0;
    end else begin
      case (state)
        SHA_IDLE: begin
          for (int i = 0; i < 8; i++) begin
            h[i] <= IV[i]; // Start every message from H(0)
            v[i] <= IV[i];
          end
          rnd       <= '0;
          pad_only  <= 1'b0;
          final_blk <= 1'b0;
          o_blk_rdy <= 1'b1;
          if (blk_acc && i_blk_sop) begin
            w         <= w_load;
            tag       <= i_blk_tag;
            bit_len   <= len_nxt;
            o_blk_rdy <= 1'b0;
            if (i_blk_eop) begin
              pad_only  <= need_pad;
              final_blk <= !need_pad;
            end
            state <= SHA_ROUNDS;
          end
        end
        SHA_ROUNDS: begin
          for (int i = 0; i < 15; i++)
            w[i] <= w[i+1];
          w[15] <= w_nxt;
          v[7] <= v[6];      // h <= g
          v[6] <= v[5];
          v[5] <= v[4];
          v[4] <= v[3] + t1; // e <= d + T1
          v[3] <= v[2];
          v[2] <= v[1];
          v[1] <= v[0];
          v[0] <= t1 + t2;   // a <= T1 + T2
          rnd  <= rnd + 6'd1;
          if (rnd == 6'(ROUNDS - 1)) begin
            rnd       <= '0;
            o_blk_rdy <= !(final_blk || pad_only); // Ask for more only mid message
            state     <= SHA_UPDATE;
          end
        end
        SHA_UPDATE: begin
          if (final_blk) begin
            for (int i = 0; i < 8; i++)
              h[i] <= h[i] + v[i];
            dig_val <= 1'b1; // Digest shows in the cycle after this update
            state   <= SHA_FINAL;
          end else if (pad_only) begin
            for (int i = 0; i < 8; i++) begin
              h[i] <= h[i] + v[i];
              v[i] <= h[i] + v[i];
            end
            w         <= w_pad;
            pad_only  <= 1'b0;
            final_blk <= 1'b1;
            state     <= SHA_ROUNDS;
          end else if (blk_acc) begin
            for (int i = 0; i < 8; i++) begin
              h[i] <= h[i] + v[i];
              v[i] <= h[i] + v[i];
            end
            w         <= w_load;
            bit_len   <= len_nxt;
            o_blk_rdy <= 1'b0;
            if (i_blk_eop) begin
              pad_only  <= need_pad;
              final_blk <= !need_pad;
            end
            state <= SHA_ROUNDS;
          end
        end
        SHA_FINAL: begin
          // Stay here with input closed until the arbiter takes the digest
          if (i_dig_rdy) begin
            dig_val <= 1'b0;
            bit_len <= '0;
            state   <= SHA_IDLE;
          end
        end
        default: state <= SHA_IDLE;
      endcase
    end
  end

  // A held digest must not move or drop while the output is stalled
  a_dig_hold: assert property (@(posedge i_clk) disable iff (i_rst)
    o_dig_val && !i_dig_rdy |=> o_dig_val && $stable(o_dig_dat) && $stable(o_dig_tag));

endmodule

//--- hdl/sha256_digest_arb.sv
/*
  Round-robin arbiter for the engines' digests onto the one output bus.
  A grant is held while the output stalls and moves on after each transfer.
  Data and tag pass through from the granted engine without a register
*/

`timescale 1ns/1ns

module sha256_digest_arb
  import sha256_pkg::*;
(
  input  logic                           i_clk,
  input  logic                           i_rst,
  input  logic [N_ENG-1:0]               i_dig_val,
  output logic [N_ENG-1:0]               o_dig_rdy,
  input  logic [N_ENG-1:0][DIG_BITS-1:0] i_dig_dat,
  input  logic [N_ENG-1:0][TAG_W-1:0]    i_dig_tag,
  output logic                           o_hash_val,
  input  logic                           i_hash_rdy,
  output logic [DIG_BITS-1:0]            o_hash_dat,
  output logic [TAG_W-1:0]               o_hash_tag
);

  logic [ENG_W-1:0] last;  // Engine served last
  logic [ENG_W-1:0] gnt;   // Grant kept across a stall
  logic             hold;
  logic [ENG_W-1:0] cur;   // Engine on the bus this cycle
  logic [ENG_W-1:0] nxt;   // Round-robin pick after last
  logic             found;

  always_comb begin
    int idx;
    nxt   = last;
    found = 1'b0;
    // Search starts one past the last served engine and wraps around
    for (int k = 1; k <= N_ENG; k++) begin
      idx = (int'(last) + k) % N_ENG;
      if (!found && i_dig_val[idx]) begin
        nxt   = ENG_W'(idx);
        found = 1'b1;
      end
    end
    cur        = hold ? gnt : nxt;
    o_hash_val = i_dig_val[cur];
    o_hash_dat = i_dig_dat[cur];
    o_hash_tag = i_dig_tag[cur];
    o_dig_rdy  = '0;
    if (o_hash_val && i_hash_rdy)
      o_dig_rdy[cur] = 1'b1;
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      last <= '0;
      gnt  <= '0;
      hold <= 1'b0;
    end else if (o_hash_val && i_hash_rdy) begin
      last <= cur; // Other engine gets first look next time
      hold <= 1'b0;
    end else if (o_hash_val) begin
      gnt  <= cur; // Stalled so this engine stays on the bus
      hold <= 1'b1;
    end
  end

  // A stalled digest keeps its engine on the bus until the output takes it
  a_gnt_hold: assert property (@(posedge i_clk) disable iff (i_rst)
    o_hash_val && !i_hash_rdy |=> o_hash_val && cur == $past(cur));

endmodule

//--- hdl/sha256_multi_top.sv
/*
  Top of the two-engine SHA-256 subsystem. The dispatcher hands messages to
  two hash engines and the arbiter merges their tagged digests on one bus.
  Digests may leave out of order, the tag tells them apart
*/

`timescale 1ns/1ns

module sha256_multi_top
  import sha256_pkg::*;
(
  input  logic                i_clk,
  input  logic                i_rst,
  input  logic                i_blk_val,
  output logic                o_blk_rdy,
  input  logic                i_blk_sop,
  input  logic                i_blk_eop,
  input  logic [MOD_W-1:0]    i_blk_mod,
  input  logic [BLK_BITS-1:0] i_blk_dat,  // Byte 0 of the message in bits 7:0
  output logic                o_hash_val,
  input  logic                i_hash_rdy,
  output logic [DIG_BITS-1:0] o_hash_dat,
  output logic [TAG_W-1:0]    o_hash_tag
);

  logic [N_ENG-1:0]               eng_val, eng_rdy;
  logic [TAG_W-1:0]               tag;
  logic [N_ENG-1:0]               dig_val, dig_rdy;
  logic [N_ENG-1:0][DIG_BITS-1:0] dig_dat;
  logic [N_ENG-1:0][TAG_W-1:0]    dig_tag;

  sha256_dispatch u_disp (
    .i_clk     (i_clk),     .i_rst     (i_rst),
    .i_blk_val (i_blk_val), .o_blk_rdy (o_blk_rdy),
    .i_blk_sop (i_blk_sop), .i_blk_eop (i_blk_eop),
    .i_eng_rdy (eng_rdy),   .o_eng_val (eng_val),   .o_tag (tag)
  );

  // Both engines see the shared data, only the owner gets valid
  sha256_core u_eng0 (
    .i_clk     (i_clk),      .i_rst     (i_rst),
    .i_blk_val (eng_val[0]), .o_blk_rdy (eng_rdy[0]),
    .i_blk_sop (i_blk_sop),  .i_blk_eop (i_blk_eop), .i_blk_mod (i_blk_mod),
    .i_blk_dat (i_blk_dat),  .i_blk_tag (tag),
    .o_dig_val (dig_val[0]), .i_dig_rdy (dig_rdy[0]),
    .o_dig_dat (dig_dat[0]), .o_dig_tag (dig_tag[0])
  );

  sha256_core u_eng1 (
    .i_clk     (i_clk),      .i_rst     (i_rst),
    .i_blk_val (eng_val[1]), .o_blk_rdy (eng_rdy[1]),
    .i_blk_sop (i_blk_sop),  .i_blk_eop (i_blk_eop), .i_blk_mod (i_blk_mod),
    .i_blk_dat (i_blk_dat),  .i_blk_tag (tag),
    .o_dig_val (dig_val[1]), .i_dig_rdy (dig_rdy[1]),
    .o_dig_dat (dig_dat[1]), .o_dig_tag (dig_tag[1])
  );

  sha256_digest_arb u_arb (
    .i_clk      (i_clk),      .i_rst      (i_rst),
    .i_dig_val  (dig_val),    .o_dig_rdy  (dig_rdy),
    .i_dig_dat  (dig_dat),    .i_dig_tag  (dig_tag),
    .o_hash_val (o_hash_val), .i_hash_rdy (i_hash_rdy),
    .o_hash_dat (o_hash_dat), .o_hash_tag (o_hash_tag)
  );

endmodule

//--- dv/sha256_multi_tb.sv
/*
  Directed testbench for the two-engine SHA-256 subsystem. A software SHA-256
  model gives the expected digests and a monitor files every digest by its tag.
  Stimulus changes on the falling edge and each wait gives up after TMO cycles
*/

`timescale 1ns/1ns

module sha256_multi_tb
  import sha256_pkg::*;
();

  localparam int TMO = 4000; // Cycle limit of any single wait
  // SHA-256 of "abc" with the first digest byte in bits 7:0
  localparam logic [DIG_BITS-1:0] ABC_DIG =
    256'had1500f261ff10b49c7a1796a36103b02322ae5dde404141eacf018fbf1678ba;

  logic                i_clk, i_rst, i_blk_val, i_blk_sop, i_blk_eop, i_hash_rdy;
  logic [MOD_W-1:0]    i_blk_mod;
  logic [BLK_BITS-1:0] i_blk_dat;
  logic                o_blk_rdy, o_hash_val;
  logic [DIG_BITS-1:0] o_hash_dat, held_dat;
  logic [TAG_W-1:0]    o_hash_tag, held_tag;
  logic [TAG_W-1:0]    nxt_tag;                // Tag the next message should be stamped with
  logic                held;                   // Last edge saw a digest stalled on the bus
  logic [DIG_BITS-1:0] got_dig [1<<TAG_W];     // Digest received under each tag
  int                  got_cnt [1<<TAG_W];
  int                  n_err, n_tmo;

  sha256_multi_top u_dut (.*);

  initial begin
    i_clk = 1'b0;
    forever #4 i_clk = ~i_clk; // 8 ns period
  end

  // Monitor that files each digest leaving the DUT under its tag
  always @(posedge i_clk) begin
    if (i_rst) begin
      held = 1'b0;
      foreach (got_cnt[t])
        got_cnt[t] = 0;
    end else begin
      if (held) begin // A stalled digest has to stay on the bus unchanged
        if (!o_hash_val) begin
          n_err++;
          $display("held digest of tag %0d dropped while i_hash_rdy was low", held_tag);
        end
        check_digest("held_digest", held_dat, o_hash_dat);
        check_tag("held_tag", held_tag, o_hash_tag);
      end
      if (o_hash_val && i_hash_rdy) begin
        got_dig[o_hash_tag] = o_hash_dat;
        got_cnt[o_hash_tag]++;
      end
      held     = o_hash_val && !i_hash_rdy;
      held_dat = o_hash_dat;
      held_tag = o_hash_tag;
    end
  end

  function automatic logic [31:0] ror32(input logic [31:0] x, input int n);
    return (x >> n) | (x << (32 - n));
  endfunction

  task automatic check_digest(input string name, input logic [DIG_BITS-1:0] exp, act);
    if (exp !== act) begin
      n_err++;
      $display("error %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_tag(input string name, input logic [TAG_W-1:0] exp, act);
    if (exp !== act) begin
      n_err++;
      $display("error %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic note_timeout(input string what);
    n_tmo++;
    $display("timeout while waiting for %s", what);
  endtask

  // Plain FIPS 180-4 SHA-256 over a byte queue, digest byte 0 lands in bits 7:0
  task automatic sha_model(input logic [7:0] msg[$], output logic [DIG_BITS-1:0] dig);
    logic [7:0]  p[$];
    logic [63:0] nbits;
    logic [31:0] hv[8], v[8], w[64];
    logic [31:0] s0, s1, t1, t2;
    int          o;
    p     = msg;
    nbits = 64'(msg.size()) * 64'd8;
    p.push_back(8'h80);
    while (p.size() % 64 != 56)
      p.push_back(8'h00);
    for (int i = 7; i >= 0; i--)
      p.push_back(nbits[i*8 +: 8]); // Length goes in big endian
    hv = IV;
    for (int blk = 0; blk < p.size() / 64; blk++) begin
      for (int t = 0; t < 64; t++) begin
        o = blk * 64 + 4 * t;
        if (t < 16) begin
          w[t] = {p[o], p[o+1], p[o+2], p[o+3]};
        end else begin
          s0   = ror32(w[t-15], 7) ^ ror32(w[t-15], 18) ^ (w[t-15] >> 3);
          s1   = ror32(w[t-2], 17) ^ ror32(w[t-2], 19) ^ (w[t-2] >> 10);
          w[t] = s1 + w[t-7] + s0 + w[t-16];
        end
      end
      v = hv;
      for (int t = 0; t < 64; t++) begin
        s1 = ror32(v[4], 6) ^ ror32(v[4], 11) ^ ror32(v[4], 25);
        s0 = ror32(v[0], 2) ^ ror32(v[0], 13) ^ ror32(v[0], 22);
        t1 = v[7] + s1 + ((v[4] & v[5]) ^ (~v[4] & v[6])) + K[t] + w[t];
        t2 = s0 + ((v[0] & v[1]) ^ (v[0] & v[2]) ^ (v[1] & v[2]));
        for (int i = 7; i > 0; i--)
          v[i] = v[i-1];
        v[4] = v[4] + t1; // e takes the old d plus T1
        v[0] = t1 + t2;
      end
      for (int i = 0; i < 8; i++)
        hv[i] = hv[i] + v[i];
    end
    for (int i = 0; i < 8; i++)
      for (int k = 0; k < 4; k++)
        dig[(4*i + k)*8 +: 8] = hv[i][31 - 8*k -: 8];
  endtask

  // Random message of len bytes together with its expected digest
  task automatic make_msg(input int len, output logic [7:0] msg[$],
                          output logic [DIG_BITS-1:0] exp);
    msg.delete();
    repeat (len)
      msg.push_back(8'($urandom));
    sha_model(msg, exp);
  endtask

  // Sends one message as blocks and returns the tag the dispatcher should give it
  task automatic send_msg(input logic [7:0] msg[$], output logic [TAG_W-1:0] tag);
    int nblk, n;
    nblk = (msg.size() + BLK_BYTS - 1) / BLK_BYTS;
    tag  = nxt_tag;
    nxt_tag++;
    for (int b = 0; b < nblk; b++) begin
      @(negedge i_clk);
      i_blk_val = 1'b1;
      i_blk_sop = (b == 0);
      i_blk_eop = (b == nblk - 1);
      i_blk_mod = MOD_W'(msg.size() % BLK_BYTS); // Only read with eop
      i_blk_dat = '0;
      for (int k = 0; k < BLK_BYTS && b * BLK_BYTS + k < msg.size(); k++)
        i_blk_dat[k*8 +: 8] = msg[b * BLK_BYTS + k];
      n = 0;
      #1;
      while (!o_blk_rdy && n < TMO) begin
        @(negedge i_clk);
        #1;
        n++;
      end
      if (!o_blk_rdy)
        note_timeout("o_blk_rdy");
      @(posedge i_clk); // The block transfers on this edge
    end
    @(negedge i_clk);
    i_blk_val = 1'b0;
  endtask

  task automatic wait_digest(input string name, input logic [TAG_W-1:0] tag,
                             input logic [DIG_BITS-1:0] exp);
    int n;
    n = 0;
    while (got_cnt[tag] == 0 && n < TMO) begin
      @(negedge i_clk);
      n++;
    end
    if (got_cnt[tag] == 0)
      note_timeout({"the digest of ", name});
    else
      check_digest(name, exp, got_dig[tag]);
  endtask

  // No digest right after reset, then "abc" has to come back under tag 0
  task automatic reset_and_abc();
    logic [7:0]          msg[$];
    logic [DIG_BITS-1:0] exp;
    logic [TAG_W-1:0]    tag;
    if (o_hash_val) begin
      n_err++;
      $display("o_hash_val is high right after reset");
    end
    msg.push_back(8'h61);
    msg.push_back(8'h62);
    msg.push_back(8'h63);
    sha_model(msg, exp);
    check_digest("abc_model", ABC_DIG, exp); // Known answer for the model itself
    send_msg(msg, tag);
    wait_digest("abc", tag, exp);
  endtask

  task automatic one_random(input string name, input int len);
    logic [7:0]          msg[$];
    logic [DIG_BITS-1:0] exp;
    logic [TAG_W-1:0]    tag;
    make_msg(len, msg, exp);
    send_msg(msg, tag);
    wait_digest(name, tag, exp);
  endtask

  // A long message on engine 0 and a short one right behind it on engine 1
  task automatic both_engines();
    logic [7:0]          ml[$], ms[$];
    logic [DIG_BITS-1:0] el, es;
    logic [TAG_W-1:0]    tl, ts;
    make_msg(300, ml, el);
    make_msg(10, ms, es);
    send_msg(ml, tl);
    send_msg(ms, ts);
    wait_digest("both_long", tl, el);  // Either may leave first
    wait_digest("both_short", ts, es);
  endtask

  // Output held low while three messages are offered
  task automatic output_stall();
    logic [7:0]          m0[$], m1[$], m2[$];
    logic [DIG_BITS-1:0] e0, e1, e2;
    logic [TAG_W-1:0]    t0, t1, t2;
    int                  gap, n;
    make_msg(20, m0, e0);
    make_msg(33, m1, e1);
    make_msg(50, m2, e2);
    gap = 20 + int'($urandom % 181);
    @(negedge i_clk);
    i_hash_rdy = 1'b0;
    fork
      begin
        send_msg(m0, t0);
        send_msg(m1, t1);
        send_msg(m2, t2); // Both engines hold a digest so this one waits
        if (got_cnt[t0] + got_cnt[t1] == 0) begin
          n_err++;
          $display("third message was taken before any held digest drained");
        end
      end
      begin
        n = 0;
        while (!o_hash_val && n < TMO) begin
          @(negedge i_clk);
          n++;
        end
        if (!o_hash_val)
          note_timeout("the first held digest");
        repeat (gap) @(negedge i_clk);
        i_hash_rdy = 1'b1;
      end
    join
    wait_digest("stall_0", t0, e0);
    wait_digest("stall_1", t1, e1);
    wait_digest("stall_2", t2, e2);
  endtask

  initial begin
    void'($urandom(69041));
    i_rst      = 1'b1;
    i_blk_val  = 1'b0;
    i_blk_sop  = 1'b0;
    i_blk_eop  = 1'b0;
    i_blk_mod  = '0;
    i_blk_dat  = '0;
    i_hash_rdy = 1'b1;
    nxt_tag    = '0;
    n_err      = 0;
    n_tmo      = 0;
    repeat (16) @(posedge i_clk);
    @(negedge i_clk);
    i_rst = 1'b0;
    reset_and_abc();
    one_random("pad_56", 56);     // Terminator fits but the length does not
    one_random("pad_64", 64);     // Full last block
    one_random("chain_130", 130);
    one_random("chain_192", 192);
    both_engines();
    output_stall();
    $display("errors %0d, timeouts %0d", n_err, n_tmo);
    if (n_err == 0 && n_tmo == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule

//--- sha256_multi.f
hdl/sha256_pkg.sv
hdl/sha256_dispatch.sv
hdl/sha256_core.sv
hdl/sha256_digest_arb.sv
hdl/sha256_multi_top.sv
dv/sha256_multi_tb.sv

//--- Makefile
TOP = sha256_multi_tb

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f sha256_multi.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TB PASSED"

clean:
	rm -rf obj_dir

.PHONY: sim clean
